// ==== include/dbg_biu_defs.svh ====
// Bus widths are fixed at 32; 64-bit data is not supported
// HPROT and HBURST are constant because every access is a single data access
`ifndef DBG_BIU_DEFS_SVH
`define DBG_BIU_DEFS_SVH

// Bus widths
`define DBG_BIU_DATA_W 32
`define DBG_BIU_ADDR_W 32

// Flops per clock-crossing chain, at least 2
`define DBG_BIU_SYNC_STAGES 2

// HPROT[0]=data, HPROT[1]=privileged
// HPROT[2]=0 non-bufferable, HPROT[3]=0 non-cacheable
`define HPROT_DBG 4'b0011

// Only single transfers are issued
`define HBURST_SINGLE 3'b000

`endif

// ==== source/ahb_lite_pkg.sv ====
// AHB-Lite bus types for a 32-bit single-transfer master
// Burst, lock and protection signals are kept outside these structs
package ahb_lite_pkg;

`include "dbg_biu_defs.svh"

  // Transfer type, master to slave
  typedef enum logic [1:0] {
    HTRANS_IDLE   = 2'b00,
    HTRANS_BUSY   = 2'b01,
    HTRANS_NONSEQ = 2'b10,
    HTRANS_SEQ    = 2'b11
  } htrans_e;

  // Transfer size, only the widths up to 32 bits
  typedef enum logic [2:0] {
    HSIZE_BYTE  = 3'b000,
    HSIZE_HWORD = 3'b001,
    HSIZE_WORD  = 3'b010
  } hsize_e;

  // Address phase plus write data
  typedef struct packed {
    logic [`DBG_BIU_ADDR_W-1:0] haddr;
    logic                       hwrite;
    hsize_e                     hsize;
    htrans_e                    htrans;
    logic [`DBG_BIU_DATA_W-1:0] hwdata;
  } ahb_req_t;

  // Slave response
  typedef struct packed {
    logic [`DBG_BIU_DATA_W-1:0] hrdata;
    logic                       hready;
    logic                       hresp;
  } ahb_rsp_t;

endpackage

// ==== source/dbg_biu_pkg.sv ====
// Debug-side command types and the AHB transfer state
// Sizes other than 1, 2 and 4 bytes are handled as word accesses
package dbg_biu_pkg;

`include "dbg_biu_defs.svh"

  // Access width in bytes, as given by the debug logic
  typedef enum logic [3:0] {
    BIU_SIZE_BYTE = 4'd1,
    BIU_SIZE_HALF = 4'd2,
    BIU_SIZE_WORD = 4'd4
  } biu_size_e;

  // Command latched in tck and read from HCLK
  // Held stable from acceptance until the done toggle returns
  typedef struct packed {
    logic [`DBG_BIU_ADDR_W-1:0] addr;
    // Already replicated over the byte lanes
    logic [`DBG_BIU_DATA_W-1:0] wdata;
    biu_size_e                  size;
    // 1 for a write, inverted from biu_rw
    logic                       write;
  } biu_cmd_t;

  // AHB master sequence
  typedef enum logic [1:0] {
    XFER_IDLE = 2'b00,
    // One cycle with HTRANS nonseq
    XFER_ADDR = 2'b01,
    // Waits for HREADY
    XFER_DATA = 2'b10
  } biu_xfer_e;

endpackage

// ==== source/dbg_toggle_sync.sv ====
// Carries a toggle into the clk domain; each change gives a one-cycle pulse
// The source must not toggle faster than the receiving side can see
`timescale 1ns/1ps
`include "dbg_biu_defs.svh"

module dbg_toggle_sync (
  input  logic clk,
  input  logic rstn,
  input  logic tgl,
  output logic pulse
);

  // Synchronizer chain, top bit is the settled copy
  logic [`DBG_BIU_SYNC_STAGES-1:0] sync_q;
  // Settled copy one cycle older, for change detection
  logic                            last_q;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      sync_q <= '0;
      last_q <= 1'b0;
    end else begin
      sync_q <= {sync_q[`DBG_BIU_SYNC_STAGES-2:0], tgl};
      last_q <= sync_q[`DBG_BIU_SYNC_STAGES-1];
    end
  end

  // Any change of the settled toggle is one event
  assign pulse = sync_q[`DBG_BIU_SYNC_STAGES-1] ^ last_q;

  // Source toggles are spaced by a full round trip
  ap_single_pulse : assert property (
    @(posedge clk) disable iff (!rstn) pulse |=> !pulse
  );

endmodule

// ==== source/dbg_lane_steer.sv ====
// Byte-lane steering for a 32-bit bus, purely combinational
// little_endian=0 mirrors the read lane select; write replication is the same
`timescale 1ns/1ps
`include "dbg_biu_defs.svh"

module dbg_lane_steer #(
  parameter bit little_endian = 1'b1
) (
  input  dbg_biu_pkg::biu_size_e     size,
  input  logic [1:0]                 addr_lsb,
  input  logic [`DBG_BIU_DATA_W-1:0] wdata_in,
  output logic [`DBG_BIU_DATA_W-1:0] wdata_out,
  input  logic [`DBG_BIU_DATA_W-1:0] hrdata,
  output logic [`DBG_BIU_DATA_W-1:0] rdata_out
);

  import dbg_biu_pkg::*;

  // Lane indices after endianness
  logic [1:0] byte_lane;
  logic       half_lane;

  assign byte_lane = little_endian ? addr_lsb : ~addr_lsb;
  assign half_lane = little_endian ? addr_lsb[1] : ~addr_lsb[1];

  ////////////////////////////////////////////////////////////////////////////
  // Write side
  ////////////////////////////////////////////////////////////////////////////

  // Top byte or halfword copied to every lane, slave picks its lane
  always_comb begin
    case (size)
      BIU_SIZE_BYTE: wdata_out = {4{wdata_in[31-:8]}};
      BIU_SIZE_HALF: wdata_out = {2{wdata_in[31-:16]}};
      default:       wdata_out = wdata_in;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read side
  ////////////////////////////////////////////////////////////////////////////

  // Selected lane moved to the bottom, upper bits zero
  always_comb begin
    case (size)
      BIU_SIZE_BYTE: rdata_out = {24'h0, hrdata[byte_lane*8 +: 8]};
      BIU_SIZE_HALF: rdata_out = {16'h0, hrdata[half_lane*16 +: 16]};
      // Word and any unlisted size pass through
      default:       rdata_out = hrdata;
    endcase
  end

endmodule

// ==== source/dbg_biu_tck_side.sv ====
// Debug side in tck; a strobe is taken only while biu_rdy is high
// Command fields have no reset and are valid only after an acceptance
`timescale 1ns/1ps
`include "dbg_biu_defs.svh"

module dbg_biu_tck_side (
  input  logic                       tck,
  input  logic                       ahb_rstn,
  input  logic                       biu_strb,
  input  logic                       biu_rw,
  input  logic [`DBG_BIU_ADDR_W-1:0] biu_addr,
  input  logic [3:0]                 biu_word_size,
  input  logic [`DBG_BIU_DATA_W-1:0] wdata_steered,
  input  logic                       done_pulse,
  output logic                       biu_rdy,
  output dbg_biu_pkg::biu_cmd_t      cmd,
  output logic                       str_tgl,
  output logic                       tck_rstn
);

  import dbg_biu_pkg::*;

  // Reset chain, asserts at once and releases on tck
  logic [`DBG_BIU_SYNC_STAGES-1:0] rst_sync_q;
  logic                            accept;

  always_ff @(posedge tck or negedge ahb_rstn) begin
    if (!ahb_rstn) begin
      rst_sync_q <= '0;
    end else begin
      rst_sync_q <= {rst_sync_q[`DBG_BIU_SYNC_STAGES-2:0], 1'b1};
    end
  end

  assign tck_rstn = rst_sync_q[`DBG_BIU_SYNC_STAGES-1];

  // Strobe counts only while idle
  assign accept = biu_strb & biu_rdy;

  // Command latch, payload only
  always_ff @(posedge tck) begin
    if (accept) begin
      cmd.addr  <= biu_addr;
      cmd.wdata <= wdata_steered;
      cmd.size  <= biu_size_e'(biu_word_size);
      cmd.write <= ~biu_rw;
    end
  end

  // Start toggle and ready flag
  always_ff @(posedge tck or negedge tck_rstn) begin
    if (!tck_rstn) begin
      str_tgl <= 1'b0;
      biu_rdy <= 1'b1;
    end else if (accept) begin
      str_tgl <= ~str_tgl;
      biu_rdy <= 1'b0;
    end else if (done_pulse) begin
      biu_rdy <= 1'b1;
    end
  end

  // Done returns only for a command in flight
  ap_done_when_busy : assert property (
    @(posedge tck) disable iff (!tck_rstn) done_pulse |-> !biu_rdy
  );

endmodule

// ==== source/dbg_biu_ahb_master.sv ====
// AHB-Lite master for one single transfer per start pulse
// HRESP is sampled only with HREADY high and the two-cycle error is not tracked
`timescale 1ns/1ps
`include "dbg_biu_defs.svh"

module dbg_biu_ahb_master (
  input  logic                       HCLK,
  input  logic                       ahb_rstn,
  input  dbg_biu_pkg::biu_cmd_t      cmd,
  input  logic                       start_pulse,
  input  logic [`DBG_BIU_DATA_W-1:0] rdata_steered,
  input  ahb_lite_pkg::ahb_rsp_t     ahb_rsp,
  output ahb_lite_pkg::ahb_req_t     ahb_req,
  output logic                       rdy_tgl,
  output logic [`DBG_BIU_DATA_W-1:0] rdata_q,
  output logic                       err_q
);

  import ahb_lite_pkg::*;
  import dbg_biu_pkg::*;

  biu_xfer_e state_q;
  htrans_e   htrans_q;
  hsize_e    hsize;
  // Start seen while a transfer runs
  logic      start_hold_q;
  logic      go;
  logic      ack;

  assign go  = start_pulse | start_hold_q;
  // Data phase completes
  assign ack = (state_q == XFER_DATA) & ahb_rsp.hready;

  ////////////////////////////////////////////////////////////////////////////
  // Transfer FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge HCLK or negedge ahb_rstn) begin
    if (!ahb_rstn) begin
      state_q      <= XFER_IDLE;
      htrans_q     <= HTRANS_IDLE;
      start_hold_q <= 1'b0;
    end else begin
      case (state_q)
        XFER_IDLE: begin
          if (go) begin
            state_q      <= XFER_ADDR;
            htrans_q     <= HTRANS_NONSEQ;
            start_hold_q <= 1'b0;
          end
        end
        XFER_ADDR: begin
          state_q  <= XFER_DATA;
          htrans_q <= HTRANS_IDLE;
        end
        XFER_DATA: begin
          if (ahb_rsp.hready) state_q <= XFER_IDLE;
        end
        default: begin
          state_q  <= XFER_IDLE;
          htrans_q <= HTRANS_IDLE;
        end
      endcase
      // Park a start that lands while busy
      if (start_pulse && state_q != XFER_IDLE) start_hold_q <= 1'b1;
    end
  end

  // Result flags and done toggle
  always_ff @(posedge HCLK or negedge ahb_rstn) begin
    if (!ahb_rstn) begin
      rdy_tgl <= 1'b0;
      err_q   <= 1'b0;
    end else if (ack) begin
      rdy_tgl <= ~rdy_tgl;
      err_q   <= ahb_rsp.hresp;
    end
  end

  // Read data held until the next acknowledge
  always_ff @(posedge HCLK) begin
    if (ack) rdata_q <= rdata_steered;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Bus drive
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (cmd.size)
      BIU_SIZE_BYTE: hsize = HSIZE_BYTE;
      BIU_SIZE_HALF: hsize = HSIZE_HWORD;
      default:       hsize = HSIZE_WORD;
    endcase
  end

  // Command is static during the transfer, so it drives the bus directly
  always_comb begin
    ahb_req.haddr  = cmd.addr;
    ahb_req.hwrite = cmd.write;
    ahb_req.hsize  = hsize;
    ahb_req.htrans = htrans_q;
    ahb_req.hwdata = cmd.wdata;
  end

  // Nonseq lasts one cycle only, so the slave must take the address at once
  ap_nonseq_in_addr : assert property (
    @(posedge HCLK) disable iff (!ahb_rstn)
    (htrans_q == HTRANS_NONSEQ) |-> (state_q == XFER_ADDR) && ahb_rsp.hready
  );

endmodule

// ==== source/dbg_biu_ahb.sv ====
// Debug bus interface, tck command side to AHB-Lite master port
// Single transfers only; hsel is held high, so one slave or a decoder downstream
`timescale 1ns/1ps
`include "dbg_biu_defs.svh"

module dbg_biu_ahb #(
  parameter bit little_endian = 1'b1
) (
  input  logic                       tck,
  input  logic                       HCLK,
  input  logic                       ahb_rstn,
  // Debug side, tck
  input  logic                       biu_strb,
  input  logic                       biu_rw,
  input  logic [`DBG_BIU_ADDR_W-1:0] biu_addr,
  input  logic [`DBG_BIU_DATA_W-1:0] biu_di,
  input  logic [3:0]                 biu_word_size,
  output logic                       biu_rdy,
  output logic [`DBG_BIU_DATA_W-1:0] biu_do,
  output logic                       biu_err,
  // AHB side, HCLK
  output ahb_lite_pkg::ahb_req_t     ahb_req,
  input  ahb_lite_pkg::ahb_rsp_t     ahb_rsp,
  output logic                       hsel,
  output logic [3:0]                 hprot,
  output logic [2:0]                 hburst,
  output logic                       hmastlock
);

  import dbg_biu_pkg::*;

  biu_cmd_t                        cmd;
  biu_size_e                       steer_size;
  logic [`DBG_BIU_DATA_W-1:0]      wdata_steered;
  logic [`DBG_BIU_DATA_W-1:0]      rdata_steered;
  logic                            str_tgl, rdy_tgl;
  logic                            start_pulse, done_pulse;
  logic                            tck_rstn;
  // HCLK reset chain
  logic [`DBG_BIU_SYNC_STAGES-1:0] hclk_rst_q;
  logic                            hclk_rstn;

  always_ff @(posedge HCLK or negedge ahb_rstn) begin
    if (!ahb_rstn) hclk_rst_q <= '0;
    else           hclk_rst_q <= {hclk_rst_q[`DBG_BIU_SYNC_STAGES-2:0], 1'b1};
  end
  assign hclk_rstn = hclk_rst_q[`DBG_BIU_SYNC_STAGES-1];

  // Idle: live size shapes write data. Busy: latched size shapes read data
  assign steer_size = biu_rdy ? biu_size_e'(biu_word_size) : cmd.size;

  dbg_lane_steer #(.little_endian(little_endian)) i_lane_steer (
    .size(steer_size), .addr_lsb(cmd.addr[1:0]),
    .wdata_in(biu_di), .wdata_out(wdata_steered),
    .hrdata(ahb_rsp.hrdata), .rdata_out(rdata_steered)
  );

  dbg_biu_tck_side i_tck_side (
    .tck, .ahb_rstn, .biu_strb, .biu_rw, .biu_addr, .biu_word_size,
    .wdata_steered, .done_pulse, .biu_rdy, .cmd, .str_tgl, .tck_rstn
  );

  // tck to HCLK start, HCLK to tck done
  dbg_toggle_sync i_start_sync (.clk(HCLK), .rstn(hclk_rstn), .tgl(str_tgl), .pulse(start_pulse));
  dbg_toggle_sync i_done_sync (.clk(tck), .rstn(tck_rstn), .tgl(rdy_tgl), .pulse(done_pulse));

  dbg_biu_ahb_master i_ahb_master (
    .HCLK, .ahb_rstn(hclk_rstn), .cmd, .start_pulse, .rdata_steered, .ahb_rsp,
    .ahb_req, .rdy_tgl, .rdata_q(biu_do), .err_q(biu_err)
  );

  // Fixed attributes of every debug access
  assign hsel      = 1'b1;
  assign hprot     = `HPROT_DBG;
  assign hburst    = `HBURST_SINGLE;
  assign hmastlock = 1'b0;

endmodule

// ==== verification/tb_dbg_biu_ahb.sv ====
// Directed testbench with a 256-word AHB memory slave behind the DUT
// Address bit 31 set gives an error response; wait states come from a seeded table
`timescale 1ns/1ps
`include "dbg_biu_defs.svh"

module tb_dbg_biu_ahb;

  import ahb_lite_pkg::*;
  import dbg_biu_pkg::*;

  localparam int unsigned hclk_period = 100;
  localparam int unsigned tck_period  = 230;
  // Accesses over all tests set the watchdog budget
  localparam int unsigned n_accesses  = 27;

  logic                       tck;
  logic                       HCLK;
  logic                       ahb_rstn;
  logic                       biu_strb;
  logic                       biu_rw;
  logic [`DBG_BIU_ADDR_W-1:0] biu_addr;
  logic [`DBG_BIU_DATA_W-1:0] biu_di;
  logic [`DBG_BIU_DATA_W-1:0] biu_do;
  logic [3:0]                 biu_word_size;
  logic                       biu_rdy;
  logic                       biu_err;
  ahb_req_t                   ahb_req;
  ahb_rsp_t                   ahb_rsp;
  logic                       hsel;
  logic                       hmastlock;
  logic [3:0]                 hprot;
  logic [2:0]                 hburst;

  // Slave model state
  logic [`DBG_BIU_DATA_W-1:0] mem [256];
  logic [`DBG_BIU_ADDR_W-1:0] d_addr;
  hsize_e                     d_size;
  logic                       d_write;
  logic                       dphase_q;
  logic                       rand_waits;
  int unsigned                waits;
  int unsigned                waits_left;
  // Wait counts drawn once after seeding
  int unsigned                wait_tab [64];
  logic [5:0]                 wait_idx;

  dbg_biu_ahb #(.little_endian(1'b1)) i_dbg_biu_ahb (
    .tck, .HCLK, .ahb_rstn, .biu_strb, .biu_rw, .biu_addr, .biu_di,
    .biu_word_size, .biu_rdy, .biu_do, .biu_err,
    .ahb_req, .ahb_rsp, .hsel, .hprot, .hburst, .hmastlock
  );

  initial begin
    HCLK = 1'b0;
    forever #(hclk_period / 2) HCLK = ~HCLK;
  end

  // Unrelated to HCLK on purpose
  initial begin
    tck = 1'b0;
    forever #(tck_period / 2) tck = ~tck;
  end

  ////////////////////////////////////////////////////////////////////////////
  // AHB slave model
  ////////////////////////////////////////////////////////////////////////////

  // Fill word that differs for every index
  function automatic logic [31:0] fill_word(input int unsigned idx);
    return 32'ha5c3_0000 ^ (idx * 32'h0001_0107);
  endfunction

  // Only lanes named by size and address low bits change
  function automatic logic [31:0] merge_lanes(input logic [31:0] old, input logic [31:0] wdata,
                                              input logic [1:0] lsb, input hsize_e size);
    logic [31:0] res;
    res = old;
    case (size)
      HSIZE_BYTE:  res[lsb*8 +: 8] = wdata[lsb*8 +: 8];
      HSIZE_HWORD: res[lsb[1]*16 +: 16] = wdata[lsb[1]*16 +: 16];
      default:     res = wdata;
    endcase
    return res;
  endfunction

  always @(posedge HCLK or negedge ahb_rstn) begin
    if (!ahb_rstn) begin
      ahb_rsp.hrdata <= '0;
      ahb_rsp.hready <= 1'b1;
      ahb_rsp.hresp  <= 1'b0;
      dphase_q       <= 1'b0;
      waits_left     <= 0;
      wait_idx       <= '0;
      for (int i = 0; i < 256; i++) mem[i] <= fill_word(i);
    end else if (ahb_req.htrans == HTRANS_NONSEQ && ahb_rsp.hready) begin
      // Address phase taken and read data ready at the end of the waits
      waits = rand_waits ? wait_tab[wait_idx] : 0;
      wait_idx       <= wait_idx + 1'b1;
      dphase_q       <= 1'b1;
      d_addr         <= ahb_req.haddr;
      d_write        <= ahb_req.hwrite;
      d_size         <= ahb_req.hsize;
      waits_left     <= waits;
      ahb_rsp.hready <= (waits == 0);
      ahb_rsp.hresp  <= ahb_req.haddr[31];
      ahb_rsp.hrdata <= mem[ahb_req.haddr[9:2]];
    end else if (dphase_q && !ahb_rsp.hready) begin
      waits_left <= waits_left - 1;
      if (waits_left == 1) ahb_rsp.hready <= 1'b1;
    end else if (dphase_q) begin
      // Data phase ends on this edge
      if (d_write && !d_addr[31]) begin
        mem[d_addr[9:2]] <= merge_lanes(mem[d_addr[9:2]], ahb_req.hwdata, d_addr[1:0], d_size);
      end
      dphase_q      <= 1'b0;
      ahb_rsp.hresp <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks and access helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic abort_run();
    $display("test failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_data(input string name, input logic [`DBG_BIU_DATA_W-1:0] exp,
                            input logic [`DBG_BIU_DATA_W-1:0] act);
    if (act !== exp) begin
      $display("FAIL %s: expected %h, actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_err(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAIL %s: expected %b, actual %b", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_htrans(input string name, input htrans_e exp, input htrans_e act);
    if (act !== exp) begin
      $display("FAIL %s: expected %b, actual %b", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_hprot(input string name, input logic [3:0] exp, input logic [3:0] act);
    if (act !== exp) begin
      $display("FAIL %s: expected %b, actual %b", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_hburst(input string name, input logic [2:0] exp, input logic [2:0] act);
    if (act !== exp) begin
      $display("FAIL %s: expected %b, actual %b", name, exp, act);
      abort_run();
    end
  endtask

  // Strobe for one tck cycle that the DUT samples on the second edge
  task automatic start_access(input logic rw, input logic [31:0] addr,
                              input logic [31:0] di, input biu_size_e size);
    @(posedge tck);
    biu_strb      <= 1'b1;
    biu_rw        <= rw;
    biu_addr      <= addr;
    biu_di        <= di;
    biu_word_size <= size;
    @(posedge tck);
    if (!biu_rdy) begin
      $display("The unit was still busy when a new access was started");
      abort_run();
    end
    biu_strb <= 1'b0;
  endtask

  // Rising biu_rdy ends the access
  task automatic wait_ready();
    @(posedge tck);
    while (!biu_rdy) @(posedge tck);
  endtask

  task automatic dbg_access(input logic rw, input logic [31:0] addr, input logic [31:0] di,
                            input biu_size_e size, output logic [31:0] rdata,
                            output logic err);
    start_access(rw, addr, di, size);
    wait_ready();
    rdata = biu_do;
    err   = biu_err;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_reset_state();
    @(posedge tck);
    check_err("reset biu_rdy", 1'b1, biu_rdy);
    check_err("reset biu_err", 1'b0, biu_err);
    check_htrans("reset htrans", HTRANS_IDLE, ahb_req.htrans);
    // Single privileged data access, never locked
    check_err("hsel", 1'b1, hsel);
    check_err("hmastlock", 1'b0, hmastlock);
    check_hprot("hprot", 4'b0011, hprot);
    check_hburst("hburst", 3'b000, hburst);
  endtask

  task automatic test_word_rw();
    logic [31:0] rd;
    logic        err;
    dbg_access(1'b0, 32'h10, 32'hdead_beef, BIU_SIZE_WORD, rd, err);
    check_err("word write err", 1'b0, err);
    dbg_access(1'b1, 32'h10, '0, BIU_SIZE_WORD, rd, err);
    check_data("word read", 32'hdead_beef, rd);
    check_err("word read err", 1'b0, err);
  endtask

  task automatic test_byte_lanes();
    logic [31:0] rd;
    logic        err;
    logic [7:0]  b [4];
    b = '{8'h11, 8'h22, 8'h33, 8'h44};
    // Byte goes in the top lane of biu_di
    for (int i = 0; i < 4; i++) begin
      dbg_access(1'b0, 32'h20 + i, {b[i], 24'h0}, BIU_SIZE_BYTE, rd, err);
    end
    dbg_access(1'b1, 32'h20, '0, BIU_SIZE_WORD, rd, err);
    check_data("byte merge", {b[3], b[2], b[1], b[0]}, rd);
    for (int i = 0; i < 4; i++) begin
      dbg_access(1'b1, 32'h20 + i, '0, BIU_SIZE_BYTE, rd, err);
      check_data($sformatf("byte read lane %0d", i), {24'h0, b[i]}, rd);
    end
  endtask

  task automatic test_halfword(input string tag, input logic [31:0] base);
    logic [31:0] rd;
    logic        err;
    dbg_access(1'b0, base, {16'hbeef, 16'h0}, BIU_SIZE_HALF, rd, err);
    dbg_access(1'b0, base + 2, {16'hcafe, 16'h0}, BIU_SIZE_HALF, rd, err);
    dbg_access(1'b1, base, '0, BIU_SIZE_WORD, rd, err);
    check_data({tag, " half merge"}, 32'hcafe_beef, rd);
    dbg_access(1'b1, base, '0, BIU_SIZE_HALF, rd, err);
    check_data({tag, " half read low"}, 32'h0000_beef, rd);
    dbg_access(1'b1, base + 2, '0, BIU_SIZE_HALF, rd, err);
    check_data({tag, " half read high"}, 32'h0000_cafe, rd);
  endtask

  task automatic test_bus_error();
    logic [31:0] rd;
    logic        err;
    dbg_access(1'b0, 32'h8000_0040, 32'h0bad_0bad, BIU_SIZE_WORD, rd, err);
    check_err("error write", 1'b1, err);
    // Good access clears the flag
    dbg_access(1'b1, 32'h10, '0, BIU_SIZE_WORD, rd, err);
    check_err("after error write", 1'b0, err);
    check_data("after error write", 32'hdead_beef, rd);
    dbg_access(1'b1, 32'h8000_0044, '0, BIU_SIZE_WORD, rd, err);
    check_err("error read", 1'b1, err);
    dbg_access(1'b1, 32'h20, '0, BIU_SIZE_WORD, rd, err);
    check_err("after error read", 1'b0, err);
    check_data("after error read", 32'h4433_2211, rd);
  endtask

  task automatic test_busy_strobe();
    logic [31:0] rd;
    logic        err;
    start_access(1'b0, 32'h60, 32'h1357_9bdf, BIU_SIZE_WORD);
    // Second write strobed while the first is in flight
    @(posedge tck);
    biu_strb <= 1'b1;
    biu_di   <= 32'h2468_ace0;
    @(posedge tck);
    if (biu_rdy) begin
      $display("The unit was ready again before the busy strobe could be given");
      abort_run();
    end
    biu_strb <= 1'b0;
    wait_ready();
    dbg_access(1'b1, 32'h60, '0, BIU_SIZE_WORD, rd, err);
    check_data("busy strobe ignored", 32'h1357_9bdf, rd);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'h9eb5_ac80));
    foreach (wait_tab[i]) wait_tab[i] = $urandom % 4;
    ahb_rstn       = 1'b0;
    biu_strb       = 1'b0;
    biu_rw         = 1'b1;
    biu_addr       = '0;
    biu_di         = '0;
    biu_word_size  = 4'd4;
    rand_waits     = 1'b0;
    ahb_rsp.hrdata = '0;
    ahb_rsp.hready = 1'b1;
    ahb_rsp.hresp  = 1'b0;
    repeat (4) @(posedge HCLK);
    ahb_rstn <= 1'b1;
    // Let the tck reset chain release
    repeat (4) @(posedge tck);
    test_reset_state();
    test_word_rw();
    test_byte_lanes();
    test_halfword("no waits", 32'h30);
    rand_waits <= 1'b1;
    test_halfword("random waits", 32'h34);
    test_bus_error();
    test_busy_strobe();
    $display("test passed");
    $finish;
  end

  initial begin
    #((n_accesses * 40 + 20) * tck_period);
    $display("Watchdog expired, the bus interface did not finish its accesses in time");
    abort_run();
  end

endmodule

// ==== filelist.f ====
+incdir+include
source/ahb_lite_pkg.sv
source/dbg_biu_pkg.sv
source/dbg_toggle_sync.sv
source/dbg_lane_steer.sv
source/dbg_biu_tck_side.sv
source/dbg_biu_ahb_master.sv
source/dbg_biu_ahb.sv
verification/tb_dbg_biu_ahb.sv

// ==== Bender.yml ====
package:
  name: dbg_biu_ahb

export_include_dirs:
  - include

sources:
  - source/ahb_lite_pkg.sv
  - source/dbg_biu_pkg.sv
  - source/dbg_toggle_sync.sv
  - source/dbg_lane_steer.sv
  - source/dbg_biu_tck_side.sv
  - source/dbg_biu_ahb_master.sv
  - source/dbg_biu_ahb.sv
  - target: test
    files:
      - verification/tb_dbg_biu_ahb.sv
